/* rtl/zap_mode16_decoder.sv */
module zap_mode16_decoder
        import zap_thumb_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Fetched word and its strobe
        input  logic [ARM_W-1:0]        i_instruction,
        input  logic                    i_instruction_valid,

        input  logic                    i_cpsr_ff_t,    // Compressed mode

        // Registered result
        output logic [DECODED_W-1:0]    o_instruction,
        output logic                    o_instruction_valid,
        output logic                    o_und
);

//////////////////////////////////////////////////////////////////////
// Decode
//////////////////////////////////////////////////////////////////////

thumb_fmt_t             fmt;
logic [ARM_W-1:0]       dp_instruction;
logic                   dp_hit;
logic [DECODED_W-1:0]   br_instruction;
logic [DECODED_W-1:0]   instruction_nxt;
logic                   und_nxt;

zap_thumb_classifier u_classifier (
        .i_halfword             (i_instruction[THUMB_W-1:0]),
        .o_fmt                  (fmt)
);

zap_thumb_dp_decoder u_dp_decoder (
        .i_halfword             (i_instruction[THUMB_W-1:0]),
        .i_fmt                  (fmt),
        .o_dp_instruction       (dp_instruction),
        .o_dp_hit               (dp_hit)
);

zap_thumb_branch_decoder u_branch_decoder (
        .i_halfword             (i_instruction[THUMB_W-1:0]),
        .i_fmt                  (fmt),
        .o_br_instruction       (br_instruction)
);

always_comb
begin
        // ARM state passes the word straight on
        instruction_nxt = {{(DECODED_W-ARM_W){1'b0}}, i_instruction};
        und_nxt         = 1'b0;

        if ( i_cpsr_ff_t )
        begin
                und_nxt = (fmt == FMT_UNDEF);   // Branch word is zero here
                if ( dp_hit )
                        instruction_nxt = {{(DECODED_W-ARM_W){1'b0}}, dp_instruction};
                else
                        instruction_nxt = br_instruction;
        end
end

//////////////////////////////////////////////////////////////////////
// Output register
//////////////////////////////////////////////////////////////////////

always_ff @ (posedge i_clk)
begin
        if ( i_reset )
        begin
                o_instruction_valid <= 1'b0;
                o_und               <= 1'b0;
                o_instruction       <= '0;
        end
        else
        begin
                o_instruction_valid <= i_instruction_valid;
                o_und               <= i_instruction_valid & und_nxt;  // Only with valid
                if ( i_instruction_valid )
                        o_instruction <= instruction_nxt;
        end
end

// Undefined only rides on a valid word, with an all zero result
a_und_valid : assert property (@(posedge i_clk)
        o_und |-> (o_instruction_valid && o_instruction == '0));

// Idle outputs once reset has been seen
a_reset_idle : assert property (@(posedge i_clk)
        $past(i_reset) |-> (!o_instruction_valid && !o_und && o_instruction == '0));

// Bits 33 and 32 stay clear in every mode
a_spare_bits : assert property (@(posedge i_clk)
        o_instruction[DECODED_W-2:ARM_W] == 2'b00);

endmodule

/* rtl/zap_thumb_branch_decoder.sv */
module zap_thumb_branch_decoder
        import zap_thumb_pkg::*;
(
        input  logic [THUMB_W-1:0]      i_halfword,
        input  thumb_fmt_t              i_fmt,
        output logic [DECODED_W-1:0]    o_br_instruction
);

localparam logic [2:0] EXT_NONE = 3'b000;      // Plain 32-bit word
localparam logic [2:0] EXT_HALF = 3'b100;      // Offset counts halfwords

//////////////////////////////////////////////////////////////////////
// Offsets
//////////////////////////////////////////////////////////////////////

logic [23:0]    off_cond;       // Sign extended imm8
logic [23:0]    off_uncond;     // Sign extended imm11

assign off_cond   = {{16{i_halfword[7]}}, i_halfword[7:0]};
assign off_uncond = {{13{i_halfword[10]}}, i_halfword[10:0]};

//////////////////////////////////////////////////////////////////////
// Expansion
//////////////////////////////////////////////////////////////////////

always_comb
begin
        case ( i_fmt )
        FMT_BRANCH_COND:
        begin
                // B<cond> with no link
                o_br_instruction = {EXT_HALF, i_halfword[11:8], 3'b101, 1'b0, off_cond};
        end
        FMT_BRANCH_UNCOND:
        begin
                o_br_instruction = {EXT_HALF, COND_AL, 3'b101, 1'b0, off_uncond};
        end
        FMT_BX:
        begin
                // Rm with H2 folded in
                o_br_instruction = {EXT_NONE, ARM_BX_TMPL[31:4], i_halfword[6:3]};
        end
        FMT_SWI:
        begin
                o_br_instruction = {EXT_NONE, ARM_SWI_TMPL[31:8], i_halfword[7:0]}; // Comment
        end
        default:
        begin
                o_br_instruction = '0;          // Not a branch format
        end
        endcase
end

endmodule

/* rtl/zap_thumb_classifier.sv */
module zap_thumb_classifier
        import zap_thumb_pkg::*;
(
        input  logic [THUMB_W-1:0]      i_halfword,     // Low halfword of fetch
        output thumb_fmt_t              o_fmt           // Matched format
);

//////////////////////////////////////////////////////////////////////
// Priority match
//////////////////////////////////////////////////////////////////////

always_comb
begin
        // First matching item wins
        casez ( i_halfword )
        P_SWI           : o_fmt = FMT_SWI;              // Ahead of cond branch
        P_BRANCH_COND   : o_fmt = FMT_BRANCH_COND;
        P_BRANCH_UNCOND : o_fmt = FMT_BRANCH_UNCOND;
        P_BX            : o_fmt = FMT_BX;               // Ahead of hi ALU
        P_ALU_HI        :
        begin
                // Op 3 left over after BX is BLX2 here
                if ( i_halfword[9:8] == 2'b11 )
                        o_fmt = FMT_UNDEF;
                else
                        o_fmt = FMT_ALU_HI;
        end
        P_ALU_LO        : o_fmt = FMT_ALU_LO;
        P_MCAS_IMM      : o_fmt = FMT_MCAS_IMM;
        P_ADD_SUB       : o_fmt = FMT_ADD_SUB;          // Ahead of shift
        P_SHIFT         : o_fmt = FMT_SHIFT;
        default         : o_fmt = FMT_UNDEF;            // Loads, BL, BKPT etc
        endcase

        // Known code, and no format claimed by one that ranks above it
        assert ( o_fmt inside {FMT_UNDEF, FMT_SHIFT, FMT_ADD_SUB, FMT_MCAS_IMM,
                               FMT_ALU_LO, FMT_ALU_HI, FMT_BX, FMT_SWI,
                               FMT_BRANCH_COND, FMT_BRANCH_UNCOND}
                 && !(o_fmt == FMT_SHIFT && i_halfword[12:11] == 2'b11)
                 && !(o_fmt == FMT_BRANCH_COND && i_halfword[11:8] == 4'b1111)
                 && !(o_fmt == FMT_ALU_HI && i_halfword[9:8] == 2'b11) )
        else
                $error("Classifier produced an unknown format code or broke priority");
end

endmodule

/* rtl/zap_thumb_dp_decoder.sv */
module zap_thumb_dp_decoder
        import zap_thumb_pkg::*;
(
        input  logic [THUMB_W-1:0]      i_halfword,
        input  thumb_fmt_t              i_fmt,
        output logic [ARM_W-1:0]        o_dp_instruction,
        output logic                    o_dp_hit        // One of our five formats
);

//////////////////////////////////////////////////////////////////////
// Operand fields
//////////////////////////////////////////////////////////////////////

logic [3:0]     rd_lo;          // Bits 2:0
logic [3:0]     rs_lo;          // Bits 5:3
logic [3:0]     rn_lo;          // Bits 8:6 as register or imm3
logic [3:0]     rd_imm;         // Bits 10:8
logic [3:0]     rd_hi;          // H1 extended
logic [3:0]     rs_hi;          // H2 extended
logic [7:0]     imm8;
shift_t         sh_imm_type;    // Shift type of format 1
alu_op_t        as_op;          // Add or subtract of format 2

assign rd_lo       = {1'b0, i_halfword[2:0]};
assign rs_lo       = {1'b0, i_halfword[5:3]};
assign rn_lo       = {1'b0, i_halfword[8:6]};
assign rd_imm      = {1'b0, i_halfword[10:8]};
assign rd_hi       = {i_halfword[7], i_halfword[2:0]};
assign rs_hi       = {i_halfword[6], i_halfword[5:3]};
assign imm8        = i_halfword[7:0];
assign sh_imm_type = shift_t'(i_halfword[12:11]);
assign as_op       = i_halfword[9] ? SUB : ADD;

//////////////////////////////////////////////////////////////////////
// Word builders
//////////////////////////////////////////////////////////////////////

// Register operand with no shift
function automatic logic [ARM_W-1:0] dp_reg (input alu_op_t op, input logic s,
        input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm);
        return {COND_AL, 2'b00, 1'b0, op, s, rn, rd, 8'd0, rm};
endfunction

// Eight bit immediate with zero rotate
function automatic logic [ARM_W-1:0] dp_imm (input alu_op_t op, input logic s,
        input logic [3:0] rn, input logic [3:0] rd, input logic [7:0] imm);
        return {COND_AL, 2'b00, 1'b1, op, s, rn, rd, 4'd0, imm};
endfunction

// MOVS Rd, Rd, <sh> Rs
function automatic logic [ARM_W-1:0] dp_rsh (input shift_t sh,
        input logic [3:0] rd, input logic [3:0] rs);
        return {COND_AL, 2'b00, 1'b0, MOV, 1'b1, rd, rd, rs, 1'b0, sh, 1'b1, rd};
endfunction

//////////////////////////////////////////////////////////////////////
// Expansion
//////////////////////////////////////////////////////////////////////

always_comb
begin
        o_dp_hit         = i_fmt inside {FMT_SHIFT, FMT_ADD_SUB, FMT_MCAS_IMM,
                                         FMT_ALU_LO, FMT_ALU_HI};
        o_dp_instruction = '0;

        case ( i_fmt )
        FMT_SHIFT:      // MOVS Rd, Rs, <sh> #imm5
                o_dp_instruction = {COND_AL, 2'b00, 1'b0, MOV, 1'b1, 4'd0, rd_lo,
                                    i_halfword[10:6], sh_imm_type, 1'b0, rs_lo};
        FMT_ADD_SUB:
        begin
                if ( i_halfword[10] )   // Immediate 3
                        o_dp_instruction = dp_imm(as_op, 1'b1, rs_lo, rd_lo, {4'd0, rn_lo});
                else
                        o_dp_instruction = dp_reg(as_op, 1'b1, rs_lo, rd_lo, rn_lo);
        end
        FMT_MCAS_IMM:
        begin
                case ( i_halfword[12:11] )
                2'd0: o_dp_instruction = dp_imm(MOV, 1'b1, rd_imm, rd_imm, imm8);
                2'd1: o_dp_instruction = dp_imm(CMP, 1'b1, rd_imm, rd_imm, imm8);
                2'd2: o_dp_instruction = dp_imm(ADD, 1'b1, rd_imm, rd_imm, imm8);
                2'd3: o_dp_instruction = dp_imm(SUB, 1'b1, rd_imm, rd_imm, imm8);
                endcase
        end
        FMT_ALU_LO:
        begin
                case ( i_halfword[9:6] )
                4'd0:  o_dp_instruction = dp_reg(AND, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd1:  o_dp_instruction = dp_reg(EOR, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd2:  o_dp_instruction = dp_rsh(LSL, rd_lo, rs_lo);
                4'd3:  o_dp_instruction = dp_rsh(LSR, rd_lo, rs_lo);
                4'd4:  o_dp_instruction = dp_rsh(ASR, rd_lo, rs_lo);
                4'd5:  o_dp_instruction = dp_reg(ADC, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd6:  o_dp_instruction = dp_reg(SBC, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd7:  o_dp_instruction = dp_rsh(ROR, rd_lo, rs_lo);
                4'd8:  o_dp_instruction = dp_reg(TST, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd9:  o_dp_instruction = dp_imm(RSB, 1'b1, rs_lo, rd_lo, 8'd0); // NEG
                4'd10: o_dp_instruction = dp_reg(CMP, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd11: o_dp_instruction = dp_reg(CMN, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd12: o_dp_instruction = dp_reg(ORR, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd13: o_dp_instruction = {COND_AL, 7'b0000_000, 1'b1, rd_lo, 4'd0,
                                           rd_lo, 4'b1001, rs_lo};              // MULS
                4'd14: o_dp_instruction = dp_reg(BIC, 1'b1, rd_lo, rd_lo, rs_lo);
                4'd15: o_dp_instruction = dp_reg(MVN, 1'b1, rd_lo, rd_lo, rs_lo);
                endcase
        end
        FMT_ALU_HI:
        begin
                // Only CMP touches flags
                case ( i_halfword[9:8] )
                2'd0:    o_dp_instruction = dp_reg(ADD, 1'b0, rd_hi, rd_hi, rs_hi);
                2'd1:    o_dp_instruction = dp_reg(CMP, 1'b1, rd_hi, rd_hi, rs_hi);
                2'd2:    o_dp_instruction = dp_reg(MOV, 1'b0, rd_hi, rd_hi, rs_hi);
                default: o_dp_instruction = '0;        // Classified as undefined
                endcase
        end
        default:
                o_dp_instruction = '0;
        endcase

        // A hit is never undefined and always carries a built word
        assert ( !o_dp_hit || (i_fmt != FMT_UNDEF && o_dp_instruction[31:28] == COND_AL) )
        else
                $error("Data processing hit on an undefined halfword or without a word");
end

endmodule

/* rtl/zap_thumb_pkg.sv */
package zap_thumb_pkg;

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

localparam int THUMB_W   = 16;  // Compressed halfword
localparam int ARM_W     = 32;  // Expanded instruction
localparam int DECODED_W = 35;  // Bit 34 flags a halfword branch offset

localparam logic [3:0] COND_AL = 4'b1110;      // Always
localparam logic [3:0] REG_SP  = 4'd13;
localparam logic [3:0] REG_PC  = 4'd15;

// Data processing opcodes, bits 24:21
typedef enum logic [3:0] {
        AND = 4'd0,
        EOR = 4'd1,
        SUB = 4'd2,
        RSB = 4'd3,
        ADD = 4'd4,
        ADC = 4'd5,
        SBC = 4'd6,
        TST = 4'd8,
        CMP = 4'd10,
        CMN = 4'd11,
        ORR = 4'd12,
        MOV = 4'd13,
        BIC = 4'd14,
        MVN = 4'd15
} alu_op_t;

typedef enum logic [1:0] {LSL = 2'd0, LSR = 2'd1, ASR = 2'd2, ROR = 2'd3} shift_t;

//////////////////////////////////////////////////////////////////////
// Halfword match patterns
//////////////////////////////////////////////////////////////////////

localparam logic [15:0] P_SHIFT         = 16'b000?_????_????_????; // Loses to add/sub
localparam logic [15:0] P_ADD_SUB       = 16'b0001_1???_????_????;
localparam logic [15:0] P_MCAS_IMM      = 16'b001?_????_????_????;
localparam logic [15:0] P_ALU_LO        = 16'b0100_00??_????_????;
localparam logic [15:0] P_ALU_HI        = 16'b0100_01??_????_????;
localparam logic [15:0] P_BX            = 16'b0100_0111_0???_????;
localparam logic [15:0] P_SWI           = 16'b1101_1111_????_????; // Cond field 1111
localparam logic [15:0] P_BRANCH_COND   = 16'b1101_????_????_????;
localparam logic [15:0] P_BRANCH_UNCOND = 16'b1110_0???_????_????;

// One code per kept format
typedef enum logic [3:0] {
        FMT_UNDEF, FMT_SHIFT, FMT_ADD_SUB, FMT_MCAS_IMM, FMT_ALU_LO,
        FMT_ALU_HI, FMT_BX, FMT_SWI, FMT_BRANCH_COND, FMT_BRANCH_UNCOND
} thumb_fmt_t;

// Templates. Low field is filled in by the branch decoder
localparam logic [ARM_W-1:0] ARM_BX_TMPL  = {COND_AL, 8'b0001_0010, REG_PC, REG_PC, REG_PC,
                                             4'b0001, 4'b0000};
localparam logic [ARM_W-1:0] ARM_SWI_TMPL = {COND_AL, 4'b1111, 24'd0};

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
        -f zap_mode16_decoder.f --top-module zap_mode16_decoder_tb \
        > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vzap_mode16_decoder_tb > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb/mode16_tests.txt */
# Columns, all hex: T bit, input word, expected undefined flag, expected 35-bit result
# Bit 34 of the result marks a halfword branch offset
# Shift by immediate
1 000000D1 0 0E1B01182
1 000017C7 0 0E1B07FC0
1 00000863 0 0E1B030A4
# Add and subtract, register then three-bit immediate
1 00001888 0 0E0910002
1 00001BF5 0 0E0565007
1 00001D51 0 0E2921005
1 00001FDB 0 0E2533007
# Eight-bit immediate MOV CMP ADD SUB
1 0000225A 0 0E3B2205A
1 00002FFF 0 0E35770FF
1 00003001 0 0E2900001
1 00003C80 0 0E2544080
# Low ALU ops 0 to 15 with Rs r1 and Rd r2
1 0000400A 0 0E0122001
1 0000404A 0 0E0322001
1 0000408A 0 0E1B22112
1 000040CA 0 0E1B22132
1 0000410A 0 0E1B22152
1 0000414A 0 0E0B22001
1 0000418A 0 0E0D22001
1 000041CA 0 0E1B22172
1 0000420A 0 0E1122001
1 0000424A 0 0E2712000
1 0000428A 0 0E1522001
1 000042CA 0 0E1722001
1 0000430A 0 0E1922001
1 0000434A 0 0E0120291
1 0000438A 0 0E1D22001
1 000043CA 0 0E1F22001
# High register ADD CMP MOV
1 00004488 0 0E0888001
1 0000456A 0 0E152200D
1 000046F1 0 0E1A9900E
# Branches, BX and SWI
1 0000D004 0 40A000004
1 0000D1FE 0 41AFFFFFE
1 0000DC7F 0 4CA00007F
1 0000E123 0 4EA000123
1 0000E7FF 0 4EAFFFFFF
1 0000E400 0 4EAFFFC00
1 00004770 0 0E12FFF1E
1 00004718 0 0E12FFF13
1 0000DF42 0 0EF000042
1 0000DFFF 0 0EF0000FF
# Upper halfword ignored in compressed mode
1 ABCD4770 0 0E12FFF1E
1 FFFFD1FE 0 41AFFFFFE
# Dropped forms raise the undefined flag
1 00006808 1 000000000
1 00004801 1 000000000
1 00005088 1 000000000
1 0000B500 1 000000000
1 0000C803 1 000000000
1 0000F000 1 000000000
1 0000F800 1 000000000
1 0000E800 1 000000000
1 000047F0 1 000000000
1 00004780 1 000000000
1 0000BE00 1 000000000
1 0000A801 1 000000000
# ARM state passes the word through
0 E3A01001 0 0E3A01001
0 0000F000 0 00000F000

/* tb/zap_mode16_decoder_tb.sv */
module zap_mode16_decoder_tb;

timeunit 1ns;
timeprecision 100ps;

localparam int timeout_cycles = 16;     // Bound on each wait for valid
localparam int random_words   = 200;
localparam int max_lines      = 500;    // Guard on the file loop

logic           i_clk;
logic           i_reset;
logic [31:0]    i_instruction;
logic           i_instruction_valid;
logic           i_cpsr_ff_t;
logic [34:0]    o_instruction;
logic           o_instruction_valid;
logic           o_und;

integer         seed;                   // Pass-through words
int             vectors_run;            // File lines applied

zap_mode16_decoder uut (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und)
);

initial
begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;     // 100 ns period
end

//////////////////////////////////////////////////////////////////////
// Reporting and checks
//////////////////////////////////////////////////////////////////////

task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
endtask

task automatic report_error(input string msg);
        $display("ERROR: %0d ns: %s", $time, msg);
        stop_with_failure();
endtask

// One registered result against its expected value
task automatic check_output(input logic exp_und, input logic [34:0] exp_instr,
        input logic [31:0] word);
        assert (o_instruction_valid === 1'b1)
        else
                report_error($sformatf("no output valid for word %h", word));
        assert (o_und === exp_und)
        else
                report_error($sformatf("o_und %b, expected %b for word %h", o_und, exp_und, word));
        assert (o_instruction === exp_instr)
        else
                report_error($sformatf("o_instruction %h, expected %h for word %h",
                                       o_instruction, exp_instr, word));
endtask

// Strobe one word, wait for valid, compare
task automatic run_vector(input logic t_bit, input logic [31:0] word,
        input logic exp_und, input logic [34:0] exp_instr);
        int cycles;
        @(posedge i_clk);
        i_cpsr_ff_t         <= t_bit;
        i_instruction       <= word;
        i_instruction_valid <= 1'b1;
        @(posedge i_clk);
        i_instruction_valid <= 1'b0;            // Single cycle strobe
        @(negedge i_clk);
        cycles = 0;
        while (o_instruction_valid !== 1'b1 && cycles < timeout_cycles)
        begin
                @(negedge i_clk);
                cycles++;
        end
        if (o_instruction_valid !== 1'b1)
        begin
                $display("Timed out: output valid never came for word %h", word);
                stop_with_failure();
        end
        assert (cycles == 0)
        else
                report_error($sformatf("valid %0d cycles late for word %h", cycles, word));
        check_output(exp_und, exp_instr, word);
        vectors_run++;
endtask

// Back-to-back ARM state words, each checked one edge later
task automatic run_pass_through(input int count);
        logic [31:0]    sent[$];
        logic [31:0]    word;
        logic [31:0]    expected;
        int             i;
        for (i = 0; i <= count; i++)
        begin
                @(posedge i_clk);
                if (i < count)
                begin
                        word = $random(seed);
                        sent.push_back(word);
                        i_cpsr_ff_t         <= 1'b0;
                        i_instruction       <= word;
                        i_instruction_valid <= 1'b1;
                end
                else
                        i_instruction_valid <= 1'b0;
                if (i > 0)
                begin
                        @(negedge i_clk);
                        expected = sent.pop_front();
                        check_output(1'b0, {3'b000, expected}, expected);  // Zero extended
                end
        end
endtask

task automatic run_file_vectors();
        int             fd;
        int             got;
        int             fields;
        int             lines;
        string          line;
        logic [31:0]    t_field;
        logic [31:0]    word;
        logic [31:0]    und_field;
        logic [34:0]    expected;
        fd = $fopen("tb/mode16_tests.txt", "r");
        if (fd == 0)
        begin
                $display("Could not open the vector file tb/mode16_tests.txt");
                stop_with_failure();
        end
        lines = 0;
        while (!$feof(fd) && lines < max_lines)
        begin
                got = $fgets(line, fd);
                lines++;
                fields = $sscanf(line, "%h %h %h %h", t_field, word, und_field, expected);
                if (got > 0 && fields == 4)     // Comments and blanks fall out here
                        run_vector(t_field[0], word, und_field[0], expected);
        end
        $fclose(fd);
        if (vectors_run == 0)
        begin
                $display("No test vectors were read from the vector file");
                stop_with_failure();
        end
endtask

//////////////////////////////////////////////////////////////////////
// Sequence
//////////////////////////////////////////////////////////////////////

initial
begin
        seed                = 32'h276fb006;
        vectors_run         = 0;
        i_reset             = 1'b1;
        i_instruction       = '0;
        i_instruction_valid = 1'b0;
        i_cpsr_ff_t         = 1'b0;

        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;

        // Idle before the first strobe
        @(negedge i_clk);
        assert (o_instruction_valid === 1'b0 && o_und === 1'b0 && o_instruction === '0)
        else
                report_error("outputs not idle after reset");

        run_pass_through(random_words);
        run_file_vectors();

        // Undefined halfword without valid gives nothing
        @(posedge i_clk);
        i_cpsr_ff_t         <= 1'b1;
        i_instruction       <= 32'h0000_f000;
        i_instruction_valid <= 1'b0;
        @(posedge i_clk);
        @(negedge i_clk);
        assert (o_instruction_valid === 1'b0 && o_und === 1'b0)
        else
                report_error("output valid or o_und raised without an input strobe");

        $display("Finished with no errors");
        $finish;
end

endmodule

/* zap_mode16_decoder.f */
rtl/zap_thumb_pkg.sv
rtl/zap_thumb_classifier.sv
rtl/zap_thumb_dp_decoder.sv
rtl/zap_thumb_branch_decoder.sv
rtl/zap_mode16_decoder.sv
tb/zap_mode16_decoder_tb.sv
